// ==== build.f ====
+incdir+hw
hw/mem_types_pkg.sv
hw/load_pipe_pkg.sv
hw/load_addr_stage.sv
hw/load_data_stage.sv
hw/store_forward_queue.sv
hw/load_writeback_stage.sv
hw/load_pipe_top.sv
verification/load_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the load pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f build.f --top-module load_pipe_tb \
    -o load_pipe_sim > build.log 2>&1 &&
./obj_dir/load_pipe_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log && exit 0 || exit 1

// ==== verification/load_pipe_testdata.txt ====
# m addr data | l base offset func dest bm data latency kill | s addr data mask
# r | b mask mispred | d addr cycles | q drains; func 0=LB 1=LH 2=LW 4=LBU 5=LHU
m 00 80f17f92
m 04 12345678
m 08 a5c3e10f
m 0c 0badcafe
m 10 deadbeef
m 14 00ff00ff
m 20 11223344
m 24 55667788
m 40 cafef00d
m 44 13579bdf
m 80 fedcba98
l 0 0 0 01 0 ffffff92 3 0
l 0 1 0 02 0 0000007f 3 0
l 0 2 4 03 0 000000f1 3 0
l 0 3 0 04 0 ffffff80 3 0
l 0 0 1 05 0 00007f92 3 0
l 0 2 1 06 0 ffff80f1 3 0
l 0 2 5 07 0 000080f1 3 0
l 0 0 2 08 0 80f17f92 3 0
l 0 4 2 09 0 12345678 3 0
l 8 1 4 0a 0 000000e1 3 0
l 8 3 0 0b 0 ffffffa5 3 0
l c 0 5 0c 0 0000cafe 3 0
l c 2 1 0d 0 00000bad 3 0
s 10 11112222 f
s 14 0000ab00 2
l 10 0 2 0e 0 11112222 3 0
l 10 4 2 0f 0 00ffabff 3 0
s 20 aaaaaaaa 3
s 20 bbbbbbbb 1
l 20 0 2 10 0 1122aabb 3 0
l 24 0 2 11 0 55667788 0 0
s 24 ffffffff f
q
r
r
r
r
r
l 10 0 2 12 0 deadbeef 3 0
l 20 0 2 13 0 11223344 3 0
l 24 0 2 14 0 55667788 3 0
q
d 40 6
l 40 0 2 15 0 cafef00d 0 0
l 44 0 5 16 0 00009bdf 0 0
l 80 1 0 17 0 ffffffba 0 0
q
l 0 4 2 18 2 12345678 0 1
b 2 1
l 0 8 2 19 4 a5c3e10f 3 0
b 4 0
q

// ==== verification/load_pipe_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "lsu_macros.svh"

module load_pipe_tb;

    import mem_types_pkg::*;
    import load_pipe_pkg::*;

    logic                 clock;
    logic                 reset;
    load_issue_t          load_issue;
    logic                 load_ready;
    logic                 store_alloc;
    store_entry_t         store_entry;
    logic                 store_retire;
    logic                 cache_req_valid;
    addr_t                cache_req_addr;
    cache_resp_t          cache_resp;
    bmask_t               b_resolve;
    logic                 b_mispred;
    logic                 wb_valid;
    dest_tag_t            wb_dest;
    logic [`LSU_XLEN-1:0] wb_data;

    logic [31:0] mem [64];
    logic [31:0] exp_dest [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_lat [$];
    logic [31:0] exp_cycle [$];
    logic [31:0] miss_line;
    int          miss_left;
    int          cycle;
    int          limit;
    int          records;
    int          errors;
    logic        stall_seen;

    load_pipe_top uut (
        .clock           (clock),
        .reset           (reset),
        .load_issue      (load_issue),
        .load_ready      (load_ready),
        .store_alloc     (store_alloc),
        .store_entry     (store_entry),
        .store_retire    (store_retire),
        .cache_req_valid (cache_req_valid),
        .cache_req_addr  (cache_req_addr),
        .cache_resp      (cache_resp),
        .b_resolve       (b_resolve),
        .b_mispred       (b_mispred),
        .wb_valid        (wb_valid),
        .wb_dest         (wb_dest),
        .wb_data         (wb_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Watchdog grows with the number of records read
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle > limit) begin
            $display("Timeout after %0d cycles, the pipeline stopped making progress", cycle);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Cache model answers the requested line and holds valid low while a miss counts down
    always @(negedge clock) begin
        logic [31:0] line;
        line = {3'b000, cache_req_addr[31:3]};
        cache_resp.byte_mask = '1;
        cache_resp.data[0] = data_word_t'(mem[(line * 2) % 64]);
        cache_resp.data[1] = data_word_t'(mem[(line * 2 + 1) % 64]);
        if (miss_left > 0 && cache_req_valid && line == miss_line) begin
            cache_resp.valid = 1'b0;
            miss_left = miss_left - 1;
        end else begin
            cache_resp.valid = 1'b1;
        end
    end

    always @(negedge clock) begin
        #2;
        if (!reset && !load_ready) begin
            stall_seen = 1'b1;
        end
    end

    always @(negedge clock) begin
        if (!reset && wb_valid) begin
            if (exp_dest.size() == 0) begin
                $display("Writeback to tag %0d arrived with no load expected", wb_dest);
                errors++;
            end else begin
                check_value("wb_dest", exp_dest[0], 32'(wb_dest));
                check_value("wb_data", exp_data[0], wb_data);
                if (exp_lat[0] != 0) begin
                    check_value("wb_latency", exp_lat[0], cycle - exp_cycle[0]);
                end
                void'(exp_dest.pop_front());
                void'(exp_data.pop_front());
                void'(exp_lat.pop_front());
                void'(exp_cycle.pop_front());
            end
        end
    end

    // Stimulus tasks start on a falling edge and return on one
    task automatic issue_load(input logic [31:0] base, input logic [31:0] offset,
                              input logic [2:0] func, input logic [31:0] dest,
                              input logic [31:0] bm, input logic [31:0] data,
                              input logic [31:0] lat, input logic [31:0] kill);
        logic accepted;
        accepted = 1'b0;
        load_issue.valid = 1'b1;
        load_issue.base = base;
        load_issue.offset = offset;
        load_issue.func = load_func_t'(func);
        load_issue.dest = dest_tag_t'(dest);
        load_issue.bm = bmask_t'(bm);
        while (!accepted) begin
            #1;
            if (load_ready) begin
                accepted = 1'b1;
            end else begin
                @(negedge clock);
            end
        end
        if (kill == 0) begin
            exp_dest.push_back(dest);
            exp_data.push_back(data);
            exp_lat.push_back(lat);
            exp_cycle.push_back(cycle);
        end
        @(negedge clock);
        load_issue.valid = 1'b0;
    endtask

    task automatic alloc_store(input logic [31:0] addr, input logic [31:0] data,
                               input logic [31:0] mask);
        store_alloc = 1'b1;
        store_entry.valid = 1'b1;
        store_entry.addr = addr_t'(addr);
        store_entry.data = data_word_t'(data);
        store_entry.byte_mask = byte_mask_t'(mask);
        @(negedge clock);
        store_alloc = 1'b0;
    endtask

    task automatic retire_store();
        store_retire = 1'b1;
        @(negedge clock);
        store_retire = 1'b0;
    endtask

    task automatic resolve_branch(input logic [31:0] mask, input logic [31:0] mispred);
        b_resolve = bmask_t'(mask);
        b_mispred = mispred[0];
        @(negedge clock);
        b_resolve = '0;
        b_mispred = 1'b0;
    endtask

    task automatic drain_loads();
        while (exp_dest.size() != 0) begin
            @(negedge clock);
        end
        repeat (3) @(negedge clock);
    endtask

    initial begin
        int          fd;
        int          code;
        string       tok;
        string       rest;
        logic [31:0] f [8];
        void'($urandom(32'h14bf));
        errors = 0;
        records = 0;
        cycle = 0;
        limit = 100;
        miss_left = 0;
        miss_line = '0;
        stall_seen = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h5a3c0000 ^ (i * 32'h01010101);
        end
        reset = 1'b1;
        load_issue = '0;
        store_alloc = 1'b0;
        store_entry = '0;
        store_retire = 1'b0;
        cache_resp = '0;
        b_resolve = '0;
        b_mispred = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        check_value("wb_valid", 32'd0, 32'(wb_valid));
        check_value("cache_req_valid", 32'd0, 32'(cache_req_valid));
        check_value("load_ready", 32'd1, 32'(load_ready));
        reset = 1'b0;
        fd = $fopen("verification/load_pipe_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    break;
                end
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                    continue;
                end
                records++;
                limit = 40 * records + 100;
                // Branch and store records follow the previous load at once to meet it in flight
                if (tok != "b" && tok != "m" && tok != "s") begin
                    repeat ($urandom_range(2)) @(negedge clock);
                end
                if (tok == "m") begin
                    code = $fscanf(fd, "%h %h", f[0], f[1]);
                    mem[f[0][7:2]] = f[1];
                end else if (tok == "l") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    issue_load(f[0], f[1], f[2][2:0], f[3], f[4], f[5], f[6], f[7]);
                end else if (tok == "s") begin
                    code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                    alloc_store(f[0], f[1], f[2]);
                end else if (tok == "r") begin
                    retire_store();
                end else if (tok == "b") begin
                    code = $fscanf(fd, "%h %h", f[0], f[1]);
                    resolve_branch(f[0], f[1]);
                end else if (tok == "d") begin
                    code = $fscanf(fd, "%h %h", f[0], f[1]);
                    #2;
                    miss_line = {3'b000, f[0][31:3]};
                    miss_left = f[1];
                    @(negedge clock);
                end else if (tok == "q") begin
                    drain_loads();
                end else begin
                    $display("Unknown record kind %s in the test data file", tok);
                    errors++;
                end
            end
            $fclose(fd);
        end
        drain_loads();
        if (exp_dest.size() != 0) begin
            $display("%0d expected writebacks never arrived", exp_dest.size());
            errors++;
        end
        check_value("load_ready_stall", 32'd1, 32'(stall_seen));
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/load_pipe_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "lsu_macros.svh"

module load_pipe_top (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire load_pipe_pkg::load_issue_t    load_issue,
    output logic                               load_ready,
    input  wire logic                          store_alloc,
    input  wire mem_types_pkg::store_entry_t   store_entry,
    input  wire logic                          store_retire,
    output logic                               cache_req_valid,
    output mem_types_pkg::addr_t               cache_req_addr,
    input  wire mem_types_pkg::cache_resp_t    cache_resp,
    input  wire load_pipe_pkg::bmask_t         b_resolve,
    input  wire logic                          b_mispred,
    output logic                               wb_valid,
    output load_pipe_pkg::dest_tag_t           wb_dest,
    output logic [`LSU_XLEN-1:0]               wb_data
);

    import mem_types_pkg::*;
    import load_pipe_pkg::*;

    load_data_packet_t   load_data_packet;
    load_result_packet_t load_result_packet;
    logic                data_free;
    sq_ptr_t             sq_tail;
    sq_ptr_t             load_sq_tail;
    data_word_t          sq_load_data;
    byte_mask_t          sq_data_mask;

    load_addr_stage u_addr (
        .clock            (clock),
        .reset            (reset),
        .load_issue       (load_issue),
        .sq_tail          (sq_tail),
        .data_free        (data_free),
        .b_resolve        (b_resolve),
        .b_mispred        (b_mispred),
        .load_data_packet (load_data_packet),
        .load_ready       (load_ready)
    );

    // Cache request address doubles as the store queue lookup address
    load_data_stage u_data (
        .clock               (clock),
        .reset               (reset),
        .load_data_packet_in (load_data_packet),
        .cache_resp          (cache_resp),
        .sq_load_data        (sq_load_data),
        .sq_data_mask        (sq_data_mask),
        .b_resolve           (b_resolve),
        .b_mispred           (b_mispred),
        .data_free           (data_free),
        .load_req_valid      (cache_req_valid),
        .load_req_addr       (cache_req_addr),
        .load_sq_tail        (load_sq_tail),
        .load_result_packet  (load_result_packet)
    );

    store_forward_queue u_sq (
        .clock        (clock),
        .reset        (reset),
        .store_alloc  (store_alloc),
        .store_entry  (store_entry),
        .store_retire (store_retire),
        .load_addr    (cache_req_addr),
        .load_sq_tail (load_sq_tail),
        .sq_tail      (sq_tail),
        .sq_load_data (sq_load_data),
        .sq_data_mask (sq_data_mask)
    );

    load_writeback_stage u_wb (
        .clock              (clock),
        .reset              (reset),
        .load_result_packet (load_result_packet),
        .wb_valid           (wb_valid),
        .wb_dest            (wb_dest),
        .wb_data            (wb_data)
    );

endmodule

`default_nettype wire

// ==== hw/load_writeback_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "lsu_macros.svh"

module load_writeback_stage (
    input  wire logic                                clock,
    input  wire logic                                reset,
    input  wire load_pipe_pkg::load_result_packet_t  load_result_packet,
    output logic                                     wb_valid,
    output load_pipe_pkg::dest_tag_t                 wb_dest,
    output logic [`LSU_XLEN-1:0]                     wb_data
);

    import load_pipe_pkg::*;

    logic [`LSU_XLEN-1:0] shifted;
    logic [`LSU_XLEN-1:0] extended;

    // Bring the addressed byte down to bit 0
    assign shifted = load_result_packet.result >> {load_result_packet.addr.b_off, 3'b000};

    always_comb begin
        case (load_result_packet.func)
            LB: begin
                extended = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
            end
            LH: begin
                extended = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
            end
            LBU: begin
                extended = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
            end
            LHU: begin
                extended = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
            end
            default: begin
                extended = shifted;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= load_result_packet.valid;
        end
    end

    // Tag and data only mean something while wb_valid is high
    always_ff @(posedge clock) begin
        wb_dest <= load_result_packet.dest;
        wb_data <= extended;
    end

endmodule

`default_nettype wire

// ==== hw/store_forward_queue.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "lsu_macros.svh"

module store_forward_queue (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          store_alloc,
    input  wire mem_types_pkg::store_entry_t   store_entry,
    input  wire logic                          store_retire,
    input  wire mem_types_pkg::addr_t          load_addr,
    input  wire mem_types_pkg::sq_ptr_t        load_sq_tail,
    output mem_types_pkg::sq_ptr_t             sq_tail,
    output mem_types_pkg::data_word_t          sq_load_data,
    output mem_types_pkg::byte_mask_t          sq_data_mask
);

    import mem_types_pkg::*;

    sq_ptr_t                    head;
    sq_ptr_t                    tail;
    logic [`LSU_SQ_DEPTH-1:0]   entry_valid;
    store_entry_t               entries [`LSU_SQ_DEPTH];
    logic [SQ_IDX_W:0]          span;
    logic [SQ_IDX_W-1:0]        slot;
    logic                       full;
    logic                       empty;

    assign sq_tail = tail;
    assign empty = (head == tail);
    assign full = (head.idx == tail.idx) && (head.wrap != tail.wrap);

    // Stores older than the load sit between head and the captured tail
    assign span = {load_sq_tail.wrap, load_sq_tail.idx} - {head.wrap, head.idx};

    // Walk oldest to youngest so the younger match overwrites each byte
    always_comb begin
        sq_load_data = '0;
        sq_data_mask = '0;
        slot = head.idx;
        for (int k = 0; k < `LSU_SQ_DEPTH; k++) begin
            slot = head.idx + SQ_IDX_W'(k);
            if ((span <= (SQ_IDX_W+1)'(`LSU_SQ_DEPTH)) && ((SQ_IDX_W+1)'(k) < span) &&
                entry_valid[slot] &&
                (entries[slot].addr.tag == load_addr.tag) &&
                (entries[slot].addr.w_idx == load_addr.w_idx)) begin
                for (int i = 0; i < BYTES_PER_WORD; i++) begin
                    if (entries[slot].byte_mask[i]) begin
                        sq_load_data.bytes[i] = entries[slot].data.bytes[i];
                        sq_data_mask[i] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            entry_valid <= '0;
        end else begin
            if (store_alloc) begin
                entry_valid[tail.idx] <= store_entry.valid;
                tail <= {tail.wrap, tail.idx} + 1'b1;
            end
            if (store_retire) begin
                entry_valid[head.idx] <= 1'b0;
                head <= {head.wrap, head.idx} + 1'b1;
            end
        end
    end

    // Payload only, validity lives in entry_valid
    always_ff @(posedge clock) begin
        if (store_alloc) begin
            entries[tail.idx] <= store_entry;
        end
    end

    no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        store_alloc |-> !full);

    no_retire_when_empty: assert property (@(posedge clock) disable iff (reset)
        store_retire |-> !empty);

endmodule

`default_nettype wire

// ==== hw/load_data_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module load_data_stage (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire load_pipe_pkg::load_data_packet_t  load_data_packet_in,
    input  wire mem_types_pkg::cache_resp_t        cache_resp,
    input  wire mem_types_pkg::data_word_t         sq_load_data,
    input  wire mem_types_pkg::byte_mask_t         sq_data_mask,
    input  wire load_pipe_pkg::bmask_t             b_resolve,
    input  wire logic                              b_mispred,
    output logic                                   data_free,
    output logic                                   load_req_valid,
    output mem_types_pkg::addr_t                   load_req_addr,
    output mem_types_pkg::sq_ptr_t                 load_sq_tail,
    output load_pipe_pkg::load_result_packet_t     load_result_packet
);

    import mem_types_pkg::*;
    import load_pipe_pkg::*;

    load_data_packet_t load_data_packet;
    load_data_packet_t held_packet;
    data_word_t        merged;
    byte_mask_t        missing;

    // Same address goes to the cache and the store queue
    assign load_req_addr = load_data_packet.addr;
    assign load_sq_tail = load_data_packet.sq_tail;
    assign load_req_valid = held_packet.valid;

    always_comb begin
        held_packet = load_data_packet;
        if (|(b_resolve & load_data_packet.bm)) begin
            held_packet.bm = load_data_packet.bm & ~b_resolve;
            if (b_mispred) begin
                held_packet = nop_load_data_packet;
            end
        end
    end

    // Store bytes take priority over the cache line
    always_comb begin
        merged = '0;
        missing = held_packet.byte_mask;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (held_packet.byte_mask[i]) begin
                if (sq_data_mask[i]) begin
                    merged.bytes[i] = sq_load_data.bytes[i];
                    missing[i] = 1'b0;
                end else if (cache_resp.valid &&
                             cache_resp.byte_mask[held_packet.addr.w_idx][i]) begin
                    merged.bytes[i] = cache_resp.data[held_packet.addr.w_idx].bytes[i];
                    missing[i] = 1'b0;
                end
            end
        end
    end

    // A miss with bytes outstanding stalls this stage and the one behind it
    assign data_free = !held_packet.valid || cache_resp.valid || (missing == '0);

    always_comb begin
        load_result_packet.valid = held_packet.valid &&
                                   (cache_resp.valid || (missing == '0));
        load_result_packet.addr = held_packet.addr;
        load_result_packet.func = held_packet.func;
        load_result_packet.dest = held_packet.dest;
        load_result_packet.bm = held_packet.bm;
        load_result_packet.result = merged;
        load_result_packet.missing = missing;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            load_data_packet <= nop_load_data_packet;
        end else if (data_free) begin
            load_data_packet <= load_data_packet_in;
        end else begin
            load_data_packet <= held_packet;
        end
    end

    // Relies on the cache returning every byte of the word once valid
    no_missing_bytes: assert property (@(posedge clock) disable iff (reset)
        load_result_packet.valid |-> (load_result_packet.missing == '0));

endmodule

`default_nettype wire

// ==== hw/load_addr_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module load_addr_stage (
    input  wire logic                             clock,
    input  wire logic                             reset,
    input  wire load_pipe_pkg::load_issue_t       load_issue,
    input  wire mem_types_pkg::sq_ptr_t           sq_tail,
    input  wire logic                             data_free,
    input  wire load_pipe_pkg::bmask_t            b_resolve,
    input  wire logic                             b_mispred,
    output load_pipe_pkg::load_data_packet_t      load_data_packet,
    output logic                                  load_ready
);

    import mem_types_pkg::*;
    import load_pipe_pkg::*;

    load_data_packet_t stage_packet;
    load_data_packet_t issue_packet;
    addr_t             issue_addr;

    assign issue_addr = addr_t'(load_issue.base + load_issue.offset);

    // An empty stage can take a load even while the data stage is stalled
    assign load_ready = data_free || !load_data_packet.valid;

    always_comb begin
        issue_packet.valid = load_issue.valid && load_ready;
        issue_packet.addr = issue_addr;
        issue_packet.func = load_issue.func;
        issue_packet.dest = load_issue.dest;
        issue_packet.bm = load_issue.bm & ~b_resolve;
        issue_packet.sq_tail = sq_tail;
        case (load_issue.func)
            LB, LBU: issue_packet.byte_mask = byte_mask_t'(1) << issue_addr.b_off;
            LH, LHU: issue_packet.byte_mask = byte_mask_t'(3) << issue_addr.b_off;
            default: issue_packet.byte_mask = '1;
        endcase
        // A branch resolving in the issue cycle already kills this load
        if (b_mispred && |(b_resolve & load_issue.bm)) begin
            issue_packet.valid = 1'b0;
        end
    end

    always_comb begin
        load_data_packet = stage_packet;
        if (|(b_resolve & stage_packet.bm)) begin
            load_data_packet.bm = stage_packet.bm & ~b_resolve;
            if (b_mispred) begin
                load_data_packet = nop_load_data_packet;
            end
        end
    end

    // While held, keep the resolved view so stale mask bits do not linger
    always_ff @(posedge clock) begin
        if (reset) begin
            stage_packet <= nop_load_data_packet;
        end else if (load_ready) begin
            stage_packet <= issue_packet;
        end else begin
            stage_packet <= load_data_packet;
        end
    end

    half_aligned: assert property (@(posedge clock) disable iff (reset)
        (load_issue.valid && load_ready && (load_issue.func inside {LH, LHU}))
            |-> !issue_addr.b_off[0]);

endmodule

`default_nettype wire

// ==== hw/load_pipe_pkg.sv ====
`default_nettype none

`include "lsu_macros.svh"

package load_pipe_pkg;

    import mem_types_pkg::*;

    localparam int DEST_W = 6;

    // Encodings follow the RISC-V funct3 field
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_func_t;

    typedef logic [`LSU_BMASK_W-1:0] bmask_t;
    typedef logic [DEST_W-1:0] dest_tag_t;

    typedef struct packed {
        logic                 valid;
        logic [`LSU_XLEN-1:0] base;
        logic [`LSU_XLEN-1:0] offset;
        load_func_t           func;
        dest_tag_t            dest;
        bmask_t               bm;
    } load_issue_t;

    typedef struct packed {
        logic       valid;
        addr_t      addr;
        load_func_t func;
        dest_tag_t  dest;
        bmask_t     bm;
        byte_mask_t byte_mask;
        sq_ptr_t    sq_tail;
    } load_data_packet_t;

    // missing holds the needed bytes that neither source has supplied
    typedef struct packed {
        logic       valid;
        addr_t      addr;
        load_func_t func;
        dest_tag_t  dest;
        bmask_t     bm;
        data_word_t result;
        byte_mask_t missing;
    } load_result_packet_t;

    localparam load_data_packet_t nop_load_data_packet = '0;
    localparam load_result_packet_t nop_load_result_packet = '0;

endpackage

`default_nettype wire

// ==== hw/mem_types_pkg.sv ====
`default_nettype none

`include "lsu_macros.svh"

package mem_types_pkg;

    localparam int BYTES_PER_WORD = `LSU_XLEN / 8;
    localparam int W_IDX_W = $clog2(`LSU_LINE_WORDS);
    localparam int B_OFF_W = $clog2(BYTES_PER_WORD);
    localparam int SQ_IDX_W = $clog2(`LSU_SQ_DEPTH);

    // Byte address split the way the cache indexes a line
    typedef struct packed {
        logic [`LSU_XLEN-B_OFF_W-W_IDX_W-1:0] tag;
        logic [W_IDX_W-1:0]                   w_idx;
        logic [B_OFF_W-1:0]                   b_off;
    } addr_t;

    typedef struct packed {
        logic [BYTES_PER_WORD-1:0][7:0] bytes;
    } data_word_t;

    typedef logic [BYTES_PER_WORD-1:0] byte_mask_t;

    // Wrap bit tells a full queue from an empty one
    typedef struct packed {
        logic                wrap;
        logic [SQ_IDX_W-1:0] idx;
    } sq_ptr_t;

    typedef struct packed {
        logic                                   valid;
        data_word_t [`LSU_LINE_WORDS-1:0]       data;
        byte_mask_t [`LSU_LINE_WORDS-1:0]       byte_mask;
    } cache_resp_t;

    // Only the word part of addr is compared, b_off is ignored
    typedef struct packed {
        logic       valid;
        addr_t      addr;
        data_word_t data;
        byte_mask_t byte_mask;
    } store_entry_t;

endpackage

`default_nettype wire

// ==== hw/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Data word width in bits
`define LSU_XLEN 32

// Words carried by one cache response line
`define LSU_LINE_WORDS 2

// Store queue entries, a power of two
`define LSU_SQ_DEPTH 8

// Outstanding branches tracked per load
`define LSU_BMASK_W 4

`endif
